// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module tb_sound -o sim_tb

run: compile
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: gain_mixer.sv
module gain_mixer import snd_cmd_pkg::*, snd_stream_pkg::*; (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        go,          // one pulse per frame
    input  mix_in_t     mix,
    input  gain_cfg_t   gain_cfg,
    output logic        out_valid,
    output snd_sample_t out_sample
);

    logic signed [8:0]  fm_g;        // 4.4 gains as positive signed
    logic signed [8:0]  pcm_g;
    logic signed [15:0] pcm_wide;    // 8 bit sample moved to the top byte
    logic signed [24:0] fm_prod;
    logic signed [24:0] pcm_prod;
    logic signed [25:0] acc;
    logic signed [25:0] scaled;      // back to integer after the 4.4 gain
    logic               clip_hi;
    logic               clip_lo;

    assign fm_g     = signed'({1'b0, gain_cfg.fm_gain});
    assign pcm_g    = signed'({1'b0, gain_cfg.pcm_gain});
    assign pcm_wide = {mix.pcm, 8'h00};
    assign fm_prod  = $signed(mix.tone) * fm_g;
    assign pcm_prod = pcm_wide * pcm_g;
    assign acc      = fm_prod + pcm_prod;   // cannot overflow 26 bits
    assign scaled   = acc >>> 4;            // drop the gain fraction
    assign clip_hi  = (scaled > SAMPLE_MAX);
    assign clip_lo  = (scaled < SAMPLE_MIN);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= go;                // one cycle after go
        end
    end

    // saturate and flag clipping
    always_ff @(posedge CLK) begin
        if (go) begin
            if (clip_hi) begin
                out_sample.value <= SAMPLE_MAX;
            end else if (clip_lo) begin
                out_sample.value <= SAMPLE_MIN;
            end else begin
                out_sample.value <= scaled[SAMPLE_W-1:0];
            end
            out_sample.peak <= clip_hi || clip_lo;
        end
    end

endmodule

// File: pcm_voice.sv
module pcm_voice import snd_cmd_pkg::*; #(
    parameter int ROM_AW = 20  // bank on the top 2 bits
) (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              step,
    input  logic              play,
    input  logic              stop,
    input  pcm_cfg_t          pcm_cfg,
    input  logic              rom_ok,
    input  logic [7:0]        rom_data,
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    output logic signed [7:0] pcm,
    output logic              done       // sample for this frame ready
);

    localparam int OFF_W = ROM_AW - 2;  // offset inside one bank

    logic [15:0]      idx;      // samples already fetched in this run
    logic [15:0]      idx_nxt;
    logic             playing;
    logic [OFF_W-1:0] offset;
    logic             fetch;    // a frame that needs the rom

    assign idx_nxt = idx + 16'd1;
    assign offset  = OFF_W'(pcm_cfg.start) + OFF_W'(idx);  // both zero extended
    assign fetch   = step && playing && !rom_req;

    // request held until ok, dropped on the following edge
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            playing <= 1'b0;
            idx     <= '0;
            rom_req <= 1'b0;
            done    <= 1'b0;
            pcm     <= '0;
        end else begin
            done <= 1'b0;
            if (rom_req) begin
                if (rom_ok) begin
                    rom_req <= 1'b0;
                    pcm     <= signed'(rom_data);
                    done    <= 1'b1;
                    idx     <= idx_nxt;
                    if (idx_nxt == pcm_cfg.len) begin
                        playing <= 1'b0;              // run finished
                    end
                end
            end else if (fetch) begin
                rom_req <= 1'b1;
            end else if (step) begin
                pcm  <= '0;                           // silent voice
                done <= 1'b1;                         // answer next cycle
            end
            if (play) begin
                idx     <= '0;
                playing <= (pcm_cfg.len != '0);       // zero length plays nothing
            end else if (stop) begin
                playing <= 1'b0;                      // fetch in flight still ends
            end
        end
    end

    // address latched at request start, stable while rom_req is high
    always_ff @(posedge CLK) begin
        if (fetch) begin
            rom_addr <= {pcm_cfg.bank, offset};
        end
    end

endmodule

// File: project.f
snd_cmd_pkg.sv
snd_stream_pkg.sv
sound_ctrl.sv
tone_osc.sv
pcm_voice.sv
gain_mixer.sv
sound_top.sv
tb_sound_assert.sv
tb_sound.sv

// File: snd_cmd_pkg.sv
package snd_cmd_pkg;

    // host write opcodes, top nibble of the command word
    typedef enum logic [3:0] {
        OP_TONE_FREQ = 4'h0,  // phase increment
        OP_TONE_AMP  = 4'h1,  // square height, 15 bit
        OP_PCM_START = 4'h2,  // start offset inside the bank
        OP_PCM_LEN   = 4'h3,  // samples per run
        OP_PCM_PLAY  = 4'h4,
        OP_PCM_STOP  = 4'h5,
        OP_BANK      = 4'h6,  // 2 bit rom bank
        OP_GAIN      = 4'h7   // fm gain high byte, pcm gain low byte
    } snd_op_e;

    typedef struct packed {
        snd_op_e     op;
        logic [15:0] data;
    } snd_cmd_t;

    typedef struct packed {
        logic [15:0] freq;  // added once per frame
        logic [14:0] amp;   // sign comes from the phase msb
    } tone_cfg_t;

    typedef struct packed {
        logic [1:0]  bank;
        logic [15:0] start;
        logic [15:0] len;
    } pcm_cfg_t;

    // both gains 4.4 unsigned
    typedef struct packed {
        logic [7:0] fm_gain;
        logic [7:0] pcm_gain;
    } gain_cfg_t;

    localparam logic [7:0] GAIN_UNITY = 8'h10;  // 1.0 in 4.4

    typedef enum logic [1:0] {F_IDLE, F_FETCH, F_MIX, F_EMIT} ctrl_state_e;

endpackage

// File: snd_stream_pkg.sv
package snd_stream_pkg;

    localparam int SAMPLE_W = 16;  // mixed output and tone width
    localparam int PCM_W    = 8;   // rom sample width, signed

    // one frame worth of channel data into the mixer
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] tone;
        logic signed [PCM_W-1:0]    pcm;
    } mix_in_t;

    // mono sample on the output stream
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] value;
        logic                       peak;  // set when the sum clipped
    } snd_sample_t;

    // saturation limits of the output word
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

endpackage

// File: sound_ctrl.sv
module sound_ctrl import snd_cmd_pkg::*; #(
    parameter int SAMPLE_DIV = 64,  // clocks between frame starts
    parameter int CREDITS    = 4    // initial and max credits
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  snd_cmd_t  cmd,
    input  logic      pause,
    input  logic      credit_ret,
    input  logic      pcm_done,
    input  logic      out_valid,
    output logic      step,
    output logic      mix_go,
    output logic      pcm_play,
    output logic      pcm_stop,
    output tone_cfg_t tone_cfg,
    output pcm_cfg_t  pcm_cfg,
    output gain_cfg_t gain_cfg
);

    localparam int DIV_W = $clog2(SAMPLE_DIV);
    localparam int CRD_W = $clog2(CREDITS + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);
    localparam logic [CRD_W-1:0] CRD_MAX  = CRD_W'(CREDITS);

    logic [DIV_W-1:0] div_cnt;
    logic [CRD_W-1:0] credits;      // samples the dac can still take
    ctrl_state_e      state;
    logic             div_hit;
    logic             frame_start;

    assign div_hit     = (div_cnt == DIV_LAST);
    // one frame in flight, so only start from idle
    assign frame_start = div_hit && (credits != '0) && !pause && (state == F_IDLE);
    assign mix_go      = (state == F_FETCH) && pcm_done;  // same cycle as done

    // free running pacing, parks at expiry until a frame can start
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (frame_start) begin
            div_cnt <= '0;
        end else if (!div_hit) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            credits <= CRD_MAX;
        end else begin
            case ({credit_ret, out_valid})  // return and take together cancel
                2'b10: begin
                    if (credits != CRD_MAX) begin  // never above the initial count
                        credits <= credits + 1'b1;
                    end
                end
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    // frame fsm, step leaves one cycle after the start decision
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= F_IDLE;
            step  <= 1'b0;
        end else begin
            step <= frame_start;
            case (state)
                F_IDLE:  state <= frame_start ? F_FETCH : F_IDLE;
                F_FETCH: state <= pcm_done ? F_MIX : F_FETCH;   // rom may stall here
                F_MIX:   state <= out_valid ? F_EMIT : F_MIX;
                F_EMIT:  state <= F_IDLE;                       // credit count settled
                default: state <= F_IDLE;
            endcase
        end
    end

    // command decode, every write taken on the cycle it is valid
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            tone_cfg <= '0;
            pcm_cfg  <= '0;
            gain_cfg <= '{fm_gain: GAIN_UNITY, pcm_gain: GAIN_UNITY};
            pcm_play <= 1'b0;
            pcm_stop <= 1'b0;
        end else begin
            pcm_play <= cmd_valid && (cmd.op == OP_PCM_PLAY);  // single cycle pulses
            pcm_stop <= cmd_valid && (cmd.op == OP_PCM_STOP);
            if (cmd_valid) begin
                case (cmd.op)
                    OP_TONE_FREQ: tone_cfg.freq  <= cmd.data;
                    OP_TONE_AMP:  tone_cfg.amp   <= cmd.data[14:0];
                    OP_PCM_START: pcm_cfg.start  <= cmd.data;
                    OP_PCM_LEN:   pcm_cfg.len    <= cmd.data;
                    OP_BANK:      pcm_cfg.bank   <= cmd.data[1:0];
                    OP_GAIN:      gain_cfg       <= cmd.data;  // fm high, pcm low
                    default:      ;                            // play/stop handled above
                endcase
            end
        end
    end

endmodule

// File: sound_top.sv
module sound_top import snd_cmd_pkg::*, snd_stream_pkg::*; #(
    parameter int SAMPLE_DIV = 64,
    parameter int CREDITS    = 4,
    parameter int ROM_AW     = 20
) (
    input  logic              CLK,
    input  logic              rst_n,
    // host command port, no back-pressure
    input  logic              cmd_valid,
    input  snd_cmd_t          cmd,
    input  logic              pause,
    // sample rom
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [7:0]        rom_data,
    // mono stream to the dac, credit based
    output logic              out_valid,
    output snd_sample_t       out_sample,
    input  logic              credit_ret
);

    logic      step;       // frame tick to both voices
    logic      mix_go;
    logic      pcm_play;
    logic      pcm_stop;
    logic      pcm_done;
    tone_cfg_t tone_cfg;
    pcm_cfg_t  pcm_cfg;
    gain_cfg_t gain_cfg;
    mix_in_t   mix;        // tone and pcm channel into the mixer

    sound_ctrl #(.SAMPLE_DIV(SAMPLE_DIV), .CREDITS(CREDITS)) u_ctrl (
        .CLK        ( CLK        ),
        .rst_n      ( rst_n      ),
        .cmd_valid  ( cmd_valid  ),
        .cmd        ( cmd        ),
        .pause      ( pause      ),
        .credit_ret ( credit_ret ),
        .pcm_done   ( pcm_done   ),
        .out_valid  ( out_valid  ),  // takes a credit
        .step       ( step       ),
        .mix_go     ( mix_go     ),
        .pcm_play   ( pcm_play   ),
        .pcm_stop   ( pcm_stop   ),
        .tone_cfg   ( tone_cfg   ),
        .pcm_cfg    ( pcm_cfg    ),
        .gain_cfg   ( gain_cfg   )
    );

    tone_osc u_tone (
        .CLK      ( CLK       ),
        .rst_n    ( rst_n     ),
        .step     ( step      ),
        .tone_cfg ( tone_cfg  ),
        .tone     ( mix.tone  )
    );

    pcm_voice #(.ROM_AW(ROM_AW)) u_pcm (
        .CLK      ( CLK       ),
        .rst_n    ( rst_n     ),
        .step     ( step      ),
        .play     ( pcm_play  ),
        .stop     ( pcm_stop  ),
        .pcm_cfg  ( pcm_cfg   ),
        .rom_ok   ( rom_ok    ),
        .rom_data ( rom_data  ),
        .rom_req  ( rom_req   ),
        .rom_addr ( rom_addr  ),
        .pcm      ( mix.pcm   ),
        .done     ( pcm_done  )
    );

    gain_mixer u_mix (
        .CLK        ( CLK        ),
        .rst_n      ( rst_n      ),
        .go         ( mix_go     ),
        .mix        ( mix        ),
        .gain_cfg   ( gain_cfg   ),
        .out_valid  ( out_valid  ),
        .out_sample ( out_sample )
    );

endmodule

// File: tb_sound.sv
module tb_sound import snd_cmd_pkg::*, snd_stream_pkg::*; ();

    localparam int SAMPLE_DIV = 16;  // short frames keep the run quick
    localparam int CREDITS    = 4;
    localparam int ROM_AW     = 20;

    logic              CLK;
    logic              rst_n;
    logic              cmd_valid;
    snd_cmd_t          cmd;
    logic              pause;
    logic              rom_req;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_ok;
    logic [7:0]        rom_data;
    logic              out_valid;
    snd_sample_t       out_sample;
    logic              credit_ret;

    logic [31:0]       lfsr = 32'h8848;
    logic [ROM_AW-1:0] addr_q[$];       // fetches seen on the rom port
    // reference model state
    logic [15:0]       m_freq, m_phase, m_start, m_len, m_idx;
    logic [14:0]       m_amp;
    logic [1:0]        m_bank;
    logic              m_playing;
    int                m_fm, m_pg;
    int                nsamp, returned, pending, peaks, errors, nchecks;
    logic              hold;            // consumer withholds credits
    logic              no_out;          // out_valid forbidden while paused

    sound_top #(.SAMPLE_DIV(SAMPLE_DIV), .CREDITS(CREDITS), .ROM_AW(ROM_AW)) dut0 (
        .CLK(CLK), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd), .pause(pause),
        .rom_req(rom_req), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .out_valid(out_valid), .out_sample(out_sample), .credit_ret(credit_ret)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic snd_sample_t expect_sample(input int t, input int p);
        longint      sum;
        longint      sc;
        snd_sample_t r;
        sum = longint'(t) * m_fm + longint'(p) * 256 * m_pg;
        sc  = sum >>> 4;  // floors like the 4.4 drop
        r.peak = 1'b1;
        if (sc > 32767) r.value = 16'sh7fff;
        else if (sc < -32768) r.value = 16'sh8000;
        else begin
            r.value = 16'(sc);
            r.peak  = 1'b0;
        end
        return r;
    endfunction

    task automatic check_sample(input snd_sample_t got, input snd_sample_t exp);
        nchecks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED out_sample value %h peak %h, expected value %h peak %h",
                     got.value, got.peak, exp.value, exp.peak);
        end
    endtask

    task automatic check_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp);
        nchecks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED rom_addr got %h expected %h", got, exp);
        end
    endtask

    // rom model answers after 0..7 random cycles
    initial begin
        int d;
        forever begin
            @(posedge CLK);
            #1;
            if (rom_req) begin
                addr_q.push_back(rom_addr);
                d = int'(rand_bits(3));
                repeat (d) @(posedge CLK);
                #1 rom_ok = 1'b1;
                rom_data = rom_addr[7:0] ^ rom_addr[15:8];
                @(posedge CLK);
                #1 rom_ok = 1'b0;
            end
        end
    end

    // output monitor with model prediction and credit return
    initial begin
        logic [ROM_AW-1:0] ea;
        int                t;
        int                p;
        snd_sample_t       e;
        forever begin
            @(posedge CLK);
            #1;
            credit_ret = 1'b0;
            if (out_valid) begin
                m_phase = m_phase + m_freq;
                t = m_phase[15] ? -int'(m_amp) : int'(m_amp);
                p = 0;
                if (m_playing) begin
                    ea = {m_bank, 18'(18'(m_start) + 18'(m_idx))};
                    if (addr_q.size() == 0) begin
                        errors++;
                        $display("no rom fetch seen for a playing pcm frame");
                    end else check_addr(addr_q.pop_front(), ea);
                    p = int'($signed(ea[7:0] ^ ea[15:8]));
                    m_idx = m_idx + 16'd1;
                    if (m_idx == m_len) m_playing = 1'b0;
                end else if (addr_q.size() != 0) begin
                    errors++;
                    $display("rom fetch seen while the pcm voice was idle");
                    addr_q.delete();
                end
                e = expect_sample(t, p);
                check_sample(out_sample, e);
                if (e.peak) peaks++;
                nsamp++;
                pending++;
                if (no_out) begin
                    errors++;
                    $display("sample emitted while paused");
                end
                if (nsamp > returned + CREDITS) begin
                    errors++;
                    $display("more samples than credits given");
                end
            end
            if (!hold && pending > 0 && rand_bits(2) == 32'd0) begin
                credit_ret = 1'b1;  // may meet a take in the same cycle
                pending--;
                returned++;
            end
        end
    end

    task automatic send_cmd(input snd_op_e op, input logic [15:0] data);
        @(posedge CLK);
        #1 cmd_valid = 1'b1;
        cmd = '{op: op, data: data};
        case (op)
            OP_TONE_FREQ: m_freq = data;
            OP_TONE_AMP:  m_amp = data[14:0];
            OP_PCM_START: m_start = data;
            OP_PCM_LEN:   m_len = data;
            OP_BANK:      m_bank = data[1:0];
            OP_GAIN: begin
                m_fm = int'(data[15:8]);
                m_pg = int'(data[7:0]);
            end
            OP_PCM_PLAY: begin
                m_idx     = '0;
                m_playing = (m_len != '0);
            end
            default: m_playing = 1'b0;  // stop
        endcase
        @(posedge CLK);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic wait_samples(input int n);
        int target;
        int cyc;
        target = nsamp + n;
        cyc    = 0;
        while (nsamp < target && cyc < 4000) begin
            @(posedge CLK);
            #1;
            cyc++;
        end
        if (nsamp < target) begin
            errors++;
            $display("timeout waiting for %0d samples", n);
        end
    endtask

    // pause and let the frame in flight finish
    task automatic drain();
        int quiet;
        int cyc;
        pause = 1'b1;
        quiet = 0;
        cyc   = 0;
        while (quiet < 16 && cyc < 500) begin
            @(posedge CLK);
            #1;
            quiet = (rom_req || out_valid) ? 0 : quiet + 1;
            cyc++;
        end
        if (quiet < 16) begin
            errors++;
            $display("timeout waiting for the frame to finish");
        end
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    initial begin
        int e0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        pause      = 1'b0;
        rom_ok     = 1'b0;
        rom_data   = '0;
        credit_ret = 1'b0;
        hold       = 1'b0;
        no_out     = 1'b0;
        m_freq     = '0;
        m_phase    = '0;
        m_start    = '0;
        m_len      = '0;
        m_idx      = '0;
        m_amp      = '0;
        m_bank     = '0;
        m_playing  = 1'b0;
        m_fm       = 16;
        m_pg       = 16;
        nsamp      = 0;
        returned   = 0;
        pending    = 0;
        peaks      = 0;
        errors     = 0;
        nchecks    = 0;
        repeat (16) @(posedge CLK);
        #1 rst_n = 1'b1;

        e0 = errors;  // tone with idle pcm voice
        drain();
        send_cmd(OP_TONE_FREQ, 16'(rand_bits(13)));
        send_cmd(OP_TONE_AMP, 16'(rand_bits(12)));
        send_cmd(OP_GAIN, {8'(rand_bits(6)), 8'h10});
        pause = 1'b0;
        wait_samples(10);
        report("tone_only", e0);

        e0 = errors;  // pcm run followed by silence
        drain();
        send_cmd(OP_BANK, 16'(rand_bits(2)));
        send_cmd(OP_PCM_START, 16'(rand_bits(16)));
        send_cmd(OP_PCM_LEN, 16'(rand_bits(3) + 32'd3));
        send_cmd(OP_PCM_PLAY, 16'h0);
        pause = 1'b0;
        wait_samples(14);
        report("pcm_playback", e0);

        e0 = errors;  // full scale tone clips
        drain();
        send_cmd(OP_TONE_AMP, 16'h7fff);
        send_cmd(OP_GAIN, 16'hff10);
        peaks = 0;
        pause = 1'b0;
        wait_samples(6);
        if (peaks == 0) begin
            errors++;
            $display("no clipped sample seen at full scale");
        end
        drain();
        send_cmd(OP_GAIN, 16'h0810);
        pause = 1'b0;
        wait_samples(6);
        report("saturation", e0);

        e0 = errors;  // credits withheld for random spans
        drain();
        send_cmd(OP_PCM_LEN, 16'd30);
        send_cmd(OP_PCM_PLAY, 16'h0);
        pause = 1'b0;
        for (int k = 0; k < 5; k++) begin
            hold = 1'b1;
            repeat (int'(rand_bits(7)) + 40) @(posedge CLK);
            #1 hold = 1'b0;
            wait_samples(3);
        end
        report("credit_flow", e0);

        e0 = errors;  // pause blocks output and stop silences pcm
        drain();
        no_out = 1'b1;
        repeat (100) @(posedge CLK);
        #1 no_out = 1'b0;
        send_cmd(OP_PCM_PLAY, 16'h0);  // voice busy when the stop lands
        pause = 1'b0;
        wait_samples(2);
        drain();
        send_cmd(OP_PCM_STOP, 16'h0);
        pause = 1'b0;
        wait_samples(5);
        report("pause_stop", e0);

        $display("checks %0d errors %0d", nchecks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb_sound_assert.sv
module tb_sound_assert #(
    parameter int CREDITS = 4,
    parameter int ROM_AW  = 20
) (
    input logic                           CLK,
    input logic                           rst_n,
    input logic [$clog2(CREDITS + 1)-1:0] credits,
    input logic                           out_valid,
    input logic                           rom_req,
    input logic [ROM_AW-1:0]              rom_addr
);

    // counter bounded by the initial credit count
    credit_max: assert property (@(posedge CLK) disable iff (!rst_n)
        credits <= ($clog2(CREDITS + 1))'(CREDITS))
        else $error("credit counter above its maximum");

    // a sample always consumes a real credit
    valid_credit: assert property (@(posedge CLK) disable iff (!rst_n)
        out_valid |-> (credits != '0))
        else $error("sample emitted with no credit");

    addr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        rom_req |=> (!rom_req || $stable(rom_addr)))  // held until ok
        else $error("rom address moved during a request");

endmodule

bind sound_top tb_sound_assert #(.CREDITS(CREDITS), .ROM_AW(ROM_AW)) u_assert (
    .CLK       ( CLK             ),
    .rst_n     ( rst_n           ),
    .credits   ( u_ctrl.credits  ),
    .out_valid ( out_valid       ),
    .rom_req   ( rom_req         ),
    .rom_addr  ( rom_addr        )
);

// File: tone_osc.sv
module tone_osc import snd_cmd_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               step,      // one pulse per frame
    input  tone_cfg_t          tone_cfg,
    output logic signed [15:0] tone
);

    // square wave stand-in for the fm chip
    // the phase msb picks the half period

    logic [15:0]        phase;
    logic [15:0]        phase_nxt;
    logic signed [15:0] amp_pos;    // amp widened, always >= 0

    assign phase_nxt = phase + tone_cfg.freq;  // wraps, period = 65536 / freq frames
    assign amp_pos   = signed'({1'b0, tone_cfg.amp});

    // output follows the phase after this frame's add,
    // so tone is valid the cycle after step
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            phase <= '0;
            tone  <= '0;
        end else if (step) begin
            phase <= phase_nxt;
            if (phase_nxt[15]) begin
                tone <= -amp_pos;     // low half
            end else begin
                tone <= amp_pos;      // high half
            end
        end
    end

endmodule
